// File: filelist.f
+incdir+testbench
hdl/cu_pkg.sv
hdl/instr_decoder.sv
hdl/uc_sequencer.sv
hdl/uc_strobes.sv
hdl/cpu_control.sv
testbench/cpu_control_tb.sv

// File: testbench/cu_ref_model.svh
`ifndef CU_REF_MODEL_SVH
`define CU_REF_MODEL_SVH

typedef logic [17:0] strobe_t;

typedef struct packed {
    strobe_t           strobes;
    cu_pkg::alu_op_e   op;     // Checked only while alu_oe is set
    cu_pkg::reg_addr_t addr;   // Checked only while regs_oe or regs_we is set
} exp_t;

// Bit positions inside the packed strobe word
localparam strobe_t S_ALU_OE    = 18'd1 << 17;
localparam strobe_t S_ALU_CARRY = 18'd1 << 16;
localparam strobe_t S_RAM_OE    = 18'd1 << 15;
localparam strobe_t S_RAM_WE    = 18'd1 << 14;
localparam strobe_t S_REGS_OE   = 18'd1 << 13;
localparam strobe_t S_REGS_WE   = 18'd1 << 12;
localparam strobe_t S_CP_OE     = 18'd1 << 11;
localparam strobe_t S_CP_WE     = 18'd1 << 10;
localparam strobe_t S_IND_SEL   = 18'd1 << 9;
localparam strobe_t S_IND_OE    = 18'd1 << 8;
localparam strobe_t S_IND_WE    = 18'd1 << 7;
localparam strobe_t S_AM_OE     = 18'd1 << 6;
localparam strobe_t S_AM_WE     = 18'd1 << 5;
localparam strobe_t S_T1_OE     = 18'd1 << 4;
localparam strobe_t S_T1_WE     = 18'd1 << 3;
localparam strobe_t S_T2_OE     = 18'd1 << 2;
localparam strobe_t S_T2_WE     = 18'd1 << 1;
localparam strobe_t S_RI_WE     = 18'd1;

exp_t exp_q[$];   // One entry per clock cycle, oldest first

function automatic void add_step(strobe_t s, cu_pkg::alu_op_e op, cu_pkg::reg_addr_t addr);
    exp_t e;
    e.strobes = s;
    e.op      = op;
    e.addr    = addr;
    exp_q.push_back(e);
endfunction

function automatic void add_fetch();
    add_step(S_CP_OE | S_AM_WE, cu_pkg::ALU_ADC, cu_pkg::REG_RA);    // AM <- CP
    add_step(S_AM_OE, cu_pkg::ALU_ADC, cu_pkg::REG_RA);
    add_step(S_RAM_OE | S_RI_WE, cu_pkg::ALU_ADC, cu_pkg::REG_RA);   // RI <- RAM
endfunction

function automatic void add_pc_increment();
    add_step(S_CP_OE | S_T1_WE, cu_pkg::ALU_ADC, cu_pkg::REG_RA);
    add_step(S_T1_OE | S_ALU_CARRY | S_ALU_OE | S_CP_WE, cu_pkg::ALU_ADC, cu_pkg::REG_RA);
endfunction

// Address in T1 or T2 goes out through the ALU, data comes back into the same temp
function automatic void add_mem_read(strobe_t t_oe, strobe_t t_we);
    add_step(t_oe | S_ALU_OE | S_AM_WE, cu_pkg::ALU_OR, cu_pkg::REG_RA);
    add_step(S_AM_OE, cu_pkg::ALU_ADC, cu_pkg::REG_RA);
    add_step(S_RAM_OE | t_we, cu_pkg::ALU_ADC, cu_pkg::REG_RA);
endfunction

////////////////////////////////////////////////////////////
// Expected cycles from decode up to the next RI load
////////////////////////////////////////////////////////////

function automatic void build_expected(cu_pkg::word_t instr, cu_pkg::word_t flags);
    cu_pkg::cls_t      cls;
    cu_pkg::subop_t    subop;
    cu_pkg::mod_t      mode;
    cu_pkg::rfield_t   rg;
    cu_pkg::rfield_t   rm;
    logic              dir;
    logic              is_1op;
    logic              is_2op;
    logic              is_jmp;
    logic              mem_src;
    logic              mem_dst;
    logic              stores;
    strobe_t           t_wr;
    strobe_t           exec_s;
    strobe_t           carry;
    cu_pkg::alu_op_e   op;
    cls    = instr[0:3];
    subop  = instr[4:6];
    mode   = instr[8:9];
    rg     = instr[10:12];
    rm     = instr[13:15];
    is_1op = (cls == cu_pkg::CLS_1OP);
    is_2op = (cls == cu_pkg::CLS_2OP_STORE) || (cls == cu_pkg::CLS_2OP_NOSTORE);
    is_jmp = (cls == cu_pkg::CLS_XFER) && (subop == 3'b101);
    dir    = is_2op && instr[7];
    add_step('0, cu_pkg::ALU_ADC, cu_pkg::REG_RA);   // Decode
    if (!(is_1op || is_2op || is_jmp) ||
        !(mode == cu_pkg::MOD_INDIRECT || mode == cu_pkg::MOD_REG)) begin
        add_pc_increment();
        add_fetch();
        return;
    end
    mem_dst = (mode == cu_pkg::MOD_INDIRECT) && !dir;
    mem_src = (mode == cu_pkg::MOD_INDIRECT) && is_2op && dir;
    t_wr    = dir ? S_T2_WE : S_T1_WE;

    if (mode == cu_pkg::MOD_INDIRECT) begin
        if (rm[0]) begin   // Base plus index
            add_step(S_REGS_OE | S_T1_WE, cu_pkg::ALU_ADC,
                     rm[1] ? cu_pkg::REG_BB : cu_pkg::REG_BA);
            add_step(S_REGS_OE | S_T2_WE, cu_pkg::ALU_ADC,
                     rm[2] ? cu_pkg::REG_XB : cu_pkg::REG_XA);
            add_step(S_T1_OE | S_T2_OE | S_ALU_OE | t_wr, cu_pkg::ALU_ADC, cu_pkg::REG_RA);
        end else begin
            add_step(S_REGS_OE | t_wr, cu_pkg::ALU_ADC, cu_pkg::REG_XA + {1'b0, rm[1:2]});
        end
    end

    if (is_2op) begin
        if (mem_src)
            add_mem_read(S_T2_OE, S_T2_WE);
        else
            add_step(S_REGS_OE | S_T2_WE, cu_pkg::ALU_ADC, dir ? rm : rg);
    end
    if (mem_dst)
        add_mem_read(S_T1_OE, S_T1_WE);
    else
        add_step(S_REGS_OE | S_T1_WE, cu_pkg::ALU_ADC, dir ? rg : rm);

    if (is_jmp) begin   // CP <- T1, no increment
        add_step(S_T1_OE | S_ALU_OE | S_CP_WE, cu_pkg::ALU_OR, cu_pkg::REG_RA);
        add_fetch();
        return;
    end

    op    = cu_pkg::ALU_ADC;
    carry = '0;
    if (is_1op) begin
        exec_s = S_T1_OE | S_ALU_OE | S_T1_WE | S_IND_SEL | S_IND_WE;
        case (subop)
            3'b000: carry = S_ALU_CARRY;                                  // INC
            3'b001: begin                                                 // DEC
                op    = cu_pkg::ALU_SBB1;
                carry = S_ALU_CARRY;
            end
            3'b010: op = cu_pkg::ALU_SBB2;                                // NEG
            3'b011: op = cu_pkg::ALU_NOT;
            3'b100: op = cu_pkg::ALU_SHL;
            3'b101: op = cu_pkg::ALU_SHR;
            3'b110: op = cu_pkg::ALU_SAR;
            default: op = cu_pkg::ALU_ADC;
        endcase
    end else begin
        exec_s = S_T1_OE | S_T2_OE | S_ALU_OE | S_T1_WE | S_IND_SEL | S_IND_WE;
        case (subop)
            3'b001: carry = flags[cu_pkg::FLAG_CARRY] ? S_ALU_CARRY : '0;   // ADC
            3'b010: op = cu_pkg::ALU_SBB1;                                  // SUB/CMP
            3'b011: begin                                                   // SBB
                op    = cu_pkg::ALU_SBB1;
                carry = flags[cu_pkg::FLAG_CARRY] ? S_ALU_CARRY : '0;
            end
            3'b100: op = cu_pkg::ALU_AND;
            3'b101: op = cu_pkg::ALU_OR;
            3'b110: op = cu_pkg::ALU_XOR;
            default: op = cu_pkg::ALU_ADC;                                  // ADD
        endcase
    end
    add_step(exec_s | carry, op, cu_pkg::REG_RA);

    stores = is_1op || (cls == cu_pkg::CLS_2OP_STORE);
    if (stores && mem_dst) begin
        add_step(S_T1_OE | S_ALU_OE | S_AM_OE | S_RAM_WE, cu_pkg::ALU_OR, cu_pkg::REG_RA);
        add_step('0, cu_pkg::ALU_ADC, cu_pkg::REG_RA);
    end else if (stores) begin
        add_step(S_T1_OE | S_ALU_OE | S_REGS_WE, cu_pkg::ALU_OR, dir ? rg : rm);
    end
    add_pc_increment();
    add_fetch();
endfunction

`endif

// File: testbench/cpu_control_tb.sv
`timescale 1ns/1ps

module cpu_control_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_INSTR    = 400;

    `include "cu_ref_model.svh"

    logic              clk;
    logic              rst;
    cu_pkg::word_t     ri;
    cu_pkg::word_t     ind;
    logic              alu_oe;
    logic              alu_carry;
    cu_pkg::alu_op_e   alu_op;
    logic              ram_oe;
    logic              ram_we;
    cu_pkg::reg_addr_t regs_addr;
    logic              regs_oe;
    logic              regs_we;
    logic              cp_oe;
    logic              cp_we;
    logic              ind_sel;
    logic              ind_oe;
    logic              ind_we;
    logic              am_oe;
    logic              am_we;
    logic              t1_oe;
    logic              t1_we;
    logic              t2_oe;
    logic              t2_we;
    logic              ri_we;
    strobe_t           act_strobes;

    int strobe_errors = 0;
    int op_errors     = 0;
    int addr_errors   = 0;
    int seq_errors    = 0;

    cpu_control dut0 (
        .clk       (clk),
        .rst       (rst),
        .ri        (ri),
        .ind       (ind),
        .alu_oe    (alu_oe),
        .alu_carry (alu_carry),
        .alu_op    (alu_op),
        .ram_oe    (ram_oe),
        .ram_we    (ram_we),
        .regs_addr (regs_addr),
        .regs_oe   (regs_oe),
        .regs_we   (regs_we),
        .cp_oe     (cp_oe),
        .cp_we     (cp_we),
        .ind_sel   (ind_sel),
        .ind_oe    (ind_oe),
        .ind_we    (ind_we),
        .am_oe     (am_oe),
        .am_we     (am_we),
        .t1_oe     (t1_oe),
        .t1_we     (t1_we),
        .t2_oe     (t2_oe),
        .t2_we     (t2_we),
        .ri_we     (ri_we)
    );

    assign act_strobes = {alu_oe, alu_carry, ram_oe, ram_we, regs_oe, regs_we, cp_oe, cp_we,
                          ind_sel, ind_oe, ind_we, am_oe, am_we, t1_oe, t1_we, t2_oe, t2_we,
                          ri_we};

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_strobes(input strobe_t exp, input strobe_t act);
        if (act !== exp) begin
            strobe_errors++;
            $display("[ERROR] strobes: expected %h, got %h at %0t", exp, act, $time);
        end
    endtask

    task automatic check_alu_op(input cu_pkg::alu_op_e exp, input cu_pkg::alu_op_e act);
        if (act !== exp) begin
            op_errors++;
            $display("[ERROR] alu_op: expected %h, got %h at %0t", exp, act, $time);
        end
    endtask

    task automatic check_regs_addr(input cu_pkg::reg_addr_t exp, input cu_pkg::reg_addr_t act);
        if (act !== exp) begin
            addr_errors++;
            $display("[ERROR] regs_addr: expected %h, got %h at %0t", exp, act, $time);
        end
    endtask

    // Mix of kept classes, dropped classes and dropped modes
    function automatic cu_pkg::word_t random_instr();
        cu_pkg::word_t w;
        int unsigned   kind;
        w    = cu_pkg::word_t'($urandom);
        kind = $urandom_range(0, 5);
        case (kind)
            0: begin
                w[0:3] = cu_pkg::CLS_1OP;
                w[4:6] = 3'($urandom_range(0, 6));
            end
            1: begin
                w[0:3] = cu_pkg::CLS_2OP_STORE;
                w[4:6] = 3'($urandom_range(0, 6));
            end
            2: begin
                w[0:3] = cu_pkg::CLS_2OP_NOSTORE;
                w[4:6] = 3'($urandom_range(0, 6));
            end
            3: begin
                w[0:3] = cu_pkg::CLS_XFER;
                w[4:6] = cu_pkg::SUBOP_JMP;
            end
            4: w[0:3] = 4'($urandom_range(6, 15));
            default: begin   // Transfers other than JMP
                w[0:3] = cu_pkg::CLS_XFER;
                w[4:6] = cu_pkg::SUBOP_JMP ^ 3'($urandom_range(1, 7));
            end
        endcase
        if ($urandom_range(0, 3) != 0)
            w[8:9] = $urandom_range(0, 1) ? cu_pkg::MOD_REG : cu_pkg::MOD_INDIRECT;
        return w;
    endfunction

    // Returns on the rising edge that ends an RI load cycle
    task automatic wait_for_fetch();
        do begin
            @(posedge clk);
        end while (ri_we !== 1'b1);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus and instruction register model
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        cu_pkg::word_t next_instr;
        cu_pkg::word_t next_flags;
        void'($urandom(32'h2552_3975));
        rst = 1'b0;
        ri  = '0;
        ind = '0;
        add_step('0, cu_pkg::ALU_ADC, cu_pkg::REG_RA);   // st_reset after release
        add_fetch();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
        for (int n = 0; n < NUM_INSTR; n++) begin
            wait_for_fetch();
            next_instr = random_instr();
            next_flags = cu_pkg::word_t'($urandom);
            ri  <= next_instr;
            ind <= next_flags;
            build_expected(next_instr, next_flags);
        end
        wait_for_fetch();   // Last instruction done
        if (exp_q.size() != 0) begin
            seq_errors++;
            $display("%0d expected cycles were never reached", exp_q.size());
        end
        $display("Error counts: strobes %0d, alu_op %0d, regs_addr %0d, sequence %0d",
                 strobe_errors, op_errors, addr_errors, seq_errors);
        if (strobe_errors + op_errors + addr_errors + seq_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Outputs settle well before the falling edge
    always @(negedge clk) begin : compare
        exp_t e;
        if (!rst) begin
            check_strobes('0, act_strobes);
        end else if (exp_q.size() == 0) begin
            seq_errors++;
            $display("No expected cycle left to compare with at %0t", $time);
        end else begin
            e = exp_q.pop_front();
            check_strobes(e.strobes, act_strobes);
            if ((e.strobes & S_ALU_OE) != '0)
                check_alu_op(e.op, alu_op);
            if ((e.strobes & (S_REGS_OE | S_REGS_WE)) != '0)
                check_regs_addr(e.addr, regs_addr);
        end
    end

    initial begin : watchdog
        #(NUM_INSTR * 20 * CLK_PERIOD + (RESET_CYCLES + 4) * CLK_PERIOD);
        $display("Timeout: %0d instructions did not finish in time", NUM_INSTR);
        $display("Something failed");
        $finish;
    end

endmodule

// File: hdl/cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
    input  logic              clk,
    input  logic              rst,
    input  cu_pkg::word_t     ri,
    input  cu_pkg::word_t     ind,
    output logic              alu_oe,
    output logic              alu_carry,
    output cu_pkg::alu_op_e   alu_op,
    output logic              ram_oe,
    output logic              ram_we,
    output cu_pkg::reg_addr_t regs_addr,
    output logic              regs_oe,
    output logic              regs_we,
    output logic              cp_oe,
    output logic              cp_we,
    output logic              ind_sel,
    output logic              ind_oe,
    output logic              ind_we,
    output logic              am_oe,
    output logic              am_we,
    output logic              t1_oe,
    output logic              t1_we,
    output logic              t2_oe,
    output logic              t2_we,
    output logic              ri_we
);

    cu_pkg::state_t  src_route;
    cu_pkg::state_t  dst_route;
    cu_pkg::state_t  exec_route;
    cu_pkg::state_t  store_route;
    cu_pkg::state_t  addr_route;
    cu_pkg::state_t  state;
    logic            dir;
    logic            dir_q;
    cu_pkg::rfield_t rg;
    cu_pkg::rfield_t rm;
    cu_pkg::subop_t  subop;

    instr_decoder decoder0 (
        .ri          (ri),
        .src_route   (src_route),
        .dst_route   (dst_route),
        .exec_route  (exec_route),
        .store_route (store_route),
        .addr_route  (addr_route),
        .dir         (dir),
        .rg          (rg),
        .rm          (rm),
        .subop       (subop)
    );

    uc_sequencer sequencer0 (
        .clk         (clk),
        .rst         (rst),
        .src_route   (src_route),
        .dst_route   (dst_route),
        .exec_route  (exec_route),
        .store_route (store_route),
        .addr_route  (addr_route),
        .dir         (dir),
        .state       (state),
        .dir_q       (dir_q)
    );

    uc_strobes strobes0 (
        .state     (state),
        .dir_q     (dir_q),
        .rg        (rg),
        .rm        (rm),
        .subop     (subop),
        .ind       (ind),
        .alu_oe    (alu_oe),
        .alu_carry (alu_carry),
        .alu_op    (alu_op),
        .ram_oe    (ram_oe),
        .ram_we    (ram_we),
        .regs_addr (regs_addr),
        .regs_oe   (regs_oe),
        .regs_we   (regs_we),
        .cp_oe     (cp_oe),
        .cp_we     (cp_we),
        .ind_sel   (ind_sel),
        .ind_oe    (ind_oe),
        .ind_we    (ind_we),
        .am_oe     (am_oe),
        .am_we     (am_we),
        .t1_oe     (t1_oe),
        .t1_we     (t1_we),
        .t2_oe     (t2_oe),
        .t2_we     (t2_we),
        .ri_we     (ri_we)
    );

endmodule

// File: hdl/uc_strobes.sv
`timescale 1ns/1ps

module uc_strobes (
    input  cu_pkg::state_t    state,
    input  logic              dir_q,
    input  cu_pkg::rfield_t   rg,
    input  cu_pkg::rfield_t   rm,
    input  cu_pkg::subop_t    subop,
    input  cu_pkg::word_t     ind,
    output logic              alu_oe,
    output logic              alu_carry,
    output cu_pkg::alu_op_e   alu_op,
    output logic              ram_oe,
    output logic              ram_we,
    output cu_pkg::reg_addr_t regs_addr,
    output logic              regs_oe,
    output logic              regs_we,
    output logic              cp_oe,
    output logic              cp_we,
    output logic              ind_sel,   // 1 takes the flags from the ALU
    output logic              ind_oe,
    output logic              ind_we,
    output logic              am_oe,
    output logic              am_we,
    output logic              t1_oe,
    output logic              t1_we,
    output logic              t2_oe,
    output logic              t2_we,
    output logic              ri_we
);

    logic carry_in;

    assign carry_in = ind[cu_pkg::FLAG_CARRY];

    always_comb begin
        alu_oe    = 1'b0;
        alu_carry = 1'b0;
        alu_op    = cu_pkg::ALU_ADC;
        ram_oe    = 1'b0;
        ram_we    = 1'b0;
        regs_addr = cu_pkg::REG_RA;
        regs_oe   = 1'b0;
        regs_we   = 1'b0;
        cp_oe     = 1'b0;
        cp_we     = 1'b0;
        ind_sel   = 1'b0;
        ind_oe    = 1'b0;
        ind_we    = 1'b0;
        am_oe     = 1'b0;
        am_we     = 1'b0;
        t1_oe     = 1'b0;
        t1_we     = 1'b0;
        t2_oe     = 1'b0;
        t2_we     = 1'b0;
        ri_we     = 1'b0;

        case (state)
            ////////////////////////////////////////////////////////////
            // Fetch and address
            ////////////////////////////////////////////////////////////
            cu_pkg::st_fetch0: begin  // AM <- CP
                cp_oe = 1'b1;
                am_we = 1'b1;
            end
            cu_pkg::st_fetch1: am_oe = 1'b1;
            cu_pkg::st_fetch2: begin  // RI <- RAM
                ram_oe = 1'b1;
                ri_we  = 1'b1;
            end
            cu_pkg::st_addr_sum0: begin
                regs_addr = rm[1] ? cu_pkg::REG_BB : cu_pkg::REG_BA;
                regs_oe   = 1'b1;
                t1_we     = 1'b1;
            end
            cu_pkg::st_addr_sum1: begin
                regs_addr = rm[2] ? cu_pkg::REG_XB : cu_pkg::REG_XA;
                regs_oe   = 1'b1;
                t2_we     = 1'b1;
            end
            cu_pkg::st_addr_sum2: begin  // Base + index, plain add
                t1_oe  = 1'b1;
                t2_oe  = 1'b1;
                alu_oe = 1'b1;
                t2_we  = dir_q;
                t1_we  = !dir_q;
            end
            cu_pkg::st_addr_reg: begin
                regs_addr = {1'b1, rm[1:2]};  // XA, XB, BA or BB
                regs_oe   = 1'b1;
                t2_we     = dir_q;
                t1_we     = !dir_q;
            end

            ////////////////////////////////////////////////////////////
            // Operand loads
            ////////////////////////////////////////////////////////////
            cu_pkg::st_src_reg: begin
                regs_addr = dir_q ? rm : rg;
                regs_oe   = 1'b1;
                t2_we     = 1'b1;
            end
            cu_pkg::st_src_mem0: begin  // AM <- T2
                t2_oe  = 1'b1;
                alu_op = cu_pkg::ALU_OR;
                alu_oe = 1'b1;
                am_we  = 1'b1;
            end
            cu_pkg::st_src_mem1: am_oe = 1'b1;
            cu_pkg::st_src_mem2: begin
                ram_oe = 1'b1;
                t2_we  = 1'b1;
            end
            cu_pkg::st_dst_reg: begin
                regs_addr = dir_q ? rg : rm;
                regs_oe   = 1'b1;
                t1_we     = 1'b1;
            end
            cu_pkg::st_dst_mem0: begin  // AM <- T1
                t1_oe  = 1'b1;
                alu_op = cu_pkg::ALU_OR;
                alu_oe = 1'b1;
                am_we  = 1'b1;
            end
            cu_pkg::st_dst_mem1: am_oe = 1'b1;
            cu_pkg::st_dst_mem2: begin
                ram_oe = 1'b1;
                t1_we  = 1'b1;
            end

            ////////////////////////////////////////////////////////////
            // Execute
            ////////////////////////////////////////////////////////////
            cu_pkg::st_exec_1op: begin  // T1 <- op T1, flags updated
                t1_oe   = 1'b1;
                alu_oe  = 1'b1;
                t1_we   = 1'b1;
                ind_sel = 1'b1;
                ind_we  = 1'b1;
                case (subop)
                    3'b000: alu_carry = 1'b1;  // INC
                    3'b001: begin              // DEC
                        alu_op    = cu_pkg::ALU_SBB1;
                        alu_carry = 1'b1;
                    end
                    3'b010: alu_op = cu_pkg::ALU_SBB2;  // NEG, 0 - T1
                    3'b011: alu_op = cu_pkg::ALU_NOT;
                    3'b100: alu_op = cu_pkg::ALU_SHL;
                    3'b101: alu_op = cu_pkg::ALU_SHR;
                    3'b110: alu_op = cu_pkg::ALU_SAR;
                    default: alu_op = cu_pkg::ALU_ADC;
                endcase
            end
            cu_pkg::st_exec_2op: begin  // T1 <- T1 op T2, flags updated
                t1_oe   = 1'b1;
                t2_oe   = 1'b1;
                alu_oe  = 1'b1;
                t1_we   = 1'b1;
                ind_sel = 1'b1;
                ind_we  = 1'b1;
                case (subop)
                    3'b001: alu_carry = carry_in;      // ADC
                    3'b010: alu_op = cu_pkg::ALU_SBB1; // SUB/CMP
                    3'b011: begin                      // SBB
                        alu_op    = cu_pkg::ALU_SBB1;
                        alu_carry = carry_in;
                    end
                    3'b100: alu_op = cu_pkg::ALU_AND;  // AND/TEST
                    3'b101: alu_op = cu_pkg::ALU_OR;
                    3'b110: alu_op = cu_pkg::ALU_XOR;
                    default: alu_op = cu_pkg::ALU_ADC; // ADD
                endcase
            end

            ////////////////////////////////////////////////////////////
            // Store, CP update
            ////////////////////////////////////////////////////////////
            cu_pkg::st_store_reg: begin
                t1_oe     = 1'b1;
                alu_op    = cu_pkg::ALU_OR;
                alu_oe    = 1'b1;
                regs_addr = dir_q ? rg : rm;
                regs_we   = 1'b1;
            end
            cu_pkg::st_store_mem0: begin  // M[AM] <- T1
                t1_oe  = 1'b1;
                alu_op = cu_pkg::ALU_OR;
                alu_oe = 1'b1;
                am_oe  = 1'b1;
                ram_we = 1'b1;
            end
            cu_pkg::st_inc_cp0: begin
                cp_oe = 1'b1;
                t1_we = 1'b1;
            end
            cu_pkg::st_inc_cp1: begin  // CP <- T1 + 1
                t1_oe     = 1'b1;
                alu_carry = 1'b1;
                alu_oe    = 1'b1;
                cp_we     = 1'b1;
            end
            cu_pkg::st_jmp: begin  // CP <- T1
                t1_oe  = 1'b1;
                alu_op = cu_pkg::ALU_OR;
                alu_oe = 1'b1;
                cp_we  = 1'b1;
            end
            default: ;  // Reset, decode and store_mem1 drive nothing
        endcase
    end

endmodule

// File: hdl/uc_sequencer.sv
`timescale 1ns/1ps

module uc_sequencer (
    input  logic           clk,
    input  logic           rst,
    input  cu_pkg::state_t src_route,
    input  cu_pkg::state_t dst_route,
    input  cu_pkg::state_t exec_route,
    input  cu_pkg::state_t store_route,
    input  cu_pkg::state_t addr_route,
    input  logic           dir,
    output cu_pkg::state_t state,
    output logic           dir_q
);

    cu_pkg::state_t state_next;
    cu_pkg::state_t src_q;
    cu_pkg::state_t dst_q;
    cu_pkg::state_t exec_q;
    cu_pkg::state_t store_q;

    ////////////////////////////////////////////////////////////
    // State and routine registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= cu_pkg::st_reset;
            src_q   <= cu_pkg::st_inc_cp0;
            dst_q   <= cu_pkg::st_inc_cp0;
            exec_q  <= cu_pkg::st_inc_cp0;
            store_q <= cu_pkg::st_inc_cp0;
            dir_q   <= 1'b0;
        end else begin
            state <= state_next;
            if (state == cu_pkg::st_decode) begin  // Routes only valid while RI is decoded
                src_q   <= src_route;
                dst_q   <= dst_route;
                exec_q  <= exec_route;
                store_q <= store_route;
                dir_q   <= dir;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////

    // Without a source, src_q already points at the destination load
    always_comb begin
        state_next = cu_pkg::st_reset;
        case (state)
            cu_pkg::st_reset:      state_next = cu_pkg::st_fetch0;
            cu_pkg::st_fetch0:     state_next = cu_pkg::st_fetch1;
            cu_pkg::st_fetch1:     state_next = cu_pkg::st_fetch2;
            cu_pkg::st_fetch2:     state_next = cu_pkg::st_decode;
            cu_pkg::st_decode:     state_next = addr_route;  // Not latched yet, take it live
            cu_pkg::st_addr_sum0:  state_next = cu_pkg::st_addr_sum1;
            cu_pkg::st_addr_sum1:  state_next = cu_pkg::st_addr_sum2;
            cu_pkg::st_addr_sum2:  state_next = src_q;
            cu_pkg::st_addr_reg:   state_next = src_q;
            cu_pkg::st_src_reg:    state_next = dst_q;
            cu_pkg::st_src_mem0:   state_next = cu_pkg::st_src_mem1;
            cu_pkg::st_src_mem1:   state_next = cu_pkg::st_src_mem2;
            cu_pkg::st_src_mem2:   state_next = dst_q;
            cu_pkg::st_dst_reg:    state_next = exec_q;
            cu_pkg::st_dst_mem0:   state_next = cu_pkg::st_dst_mem1;
            cu_pkg::st_dst_mem1:   state_next = cu_pkg::st_dst_mem2;
            cu_pkg::st_dst_mem2:   state_next = exec_q;
            cu_pkg::st_exec_1op:   state_next = store_q;
            cu_pkg::st_exec_2op:   state_next = store_q;
            cu_pkg::st_store_reg:  state_next = cu_pkg::st_inc_cp0;
            cu_pkg::st_store_mem0: state_next = cu_pkg::st_store_mem1;
            cu_pkg::st_store_mem1: state_next = cu_pkg::st_inc_cp0;
            cu_pkg::st_inc_cp0:    state_next = cu_pkg::st_inc_cp1;
            cu_pkg::st_inc_cp1:    state_next = cu_pkg::st_fetch0;
            cu_pkg::st_jmp:        state_next = cu_pkg::st_fetch0;  // CP already loaded
            default:               state_next = cu_pkg::st_reset;
        endcase
    end

endmodule

// File: hdl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  cu_pkg::word_t   ri,
    output cu_pkg::state_t  src_route,
    output cu_pkg::state_t  dst_route,
    output cu_pkg::state_t  exec_route,
    output cu_pkg::state_t  store_route,
    output cu_pkg::state_t  addr_route,
    output logic            dir,
    output cu_pkg::rfield_t rg,
    output cu_pkg::rfield_t rm,
    output cu_pkg::subop_t  subop
);

    cu_pkg::cls_t cls;
    cu_pkg::mod_t mod;
    logic         d;
    logic         mod_ok;   // Only indirect and register modes are kept
    logic         is_jmp;
    logic         known;    // Instruction has a routine of its own

    assign cls   = ri[0:3];
    assign subop = ri[4:6];
    assign d     = ri[7];
    assign mod   = ri[8:9];
    assign rg    = ri[10:12];
    assign rm    = ri[13:15];

    assign mod_ok = (mod == cu_pkg::MOD_INDIRECT) || (mod == cu_pkg::MOD_REG);
    assign is_jmp = (cls == cu_pkg::CLS_XFER) && (subop == cu_pkg::SUBOP_JMP);

    always_comb begin
        src_route   = cu_pkg::st_inc_cp0;
        dst_route   = cu_pkg::st_inc_cp0;
        exec_route  = cu_pkg::st_inc_cp0;
        store_route = cu_pkg::st_inc_cp0;
        addr_route  = cu_pkg::st_inc_cp0;
        dir         = 1'b0;
        known       = 1'b0;

        if (mod_ok) begin
            if (cls == cu_pkg::CLS_1OP || is_jmp) begin
                known     = 1'b1;
                dst_route = (mod == cu_pkg::MOD_REG) ? cu_pkg::st_dst_reg
                                                     : cu_pkg::st_dst_mem0;
                src_route = dst_route;  // No source, skip straight to destination
                if (is_jmp) begin
                    exec_route = cu_pkg::st_jmp;
                end else begin
                    exec_route  = cu_pkg::st_exec_1op;
                    store_route = (mod == cu_pkg::MOD_REG) ? cu_pkg::st_store_reg
                                                           : cu_pkg::st_store_mem0;
                end
            end else if (cls == cu_pkg::CLS_2OP_STORE || cls == cu_pkg::CLS_2OP_NOSTORE) begin
                known      = 1'b1;
                dir        = d;
                exec_route = cu_pkg::st_exec_2op;
                if (mod == cu_pkg::MOD_REG) begin
                    src_route = cu_pkg::st_src_reg;
                    dst_route = cu_pkg::st_dst_reg;
                end else if (d) begin   // REG <- REG op [mem]
                    src_route = cu_pkg::st_src_mem0;
                    dst_route = cu_pkg::st_dst_reg;
                end else begin          // [mem] <- [mem] op REG
                    src_route = cu_pkg::st_src_reg;
                    dst_route = cu_pkg::st_dst_mem0;
                end
                if (cls == cu_pkg::CLS_2OP_STORE) begin
                    store_route = (dst_route == cu_pkg::st_dst_reg) ? cu_pkg::st_store_reg
                                                                    : cu_pkg::st_store_mem0;
                end
            end
        end

        // Address routine first for indirect mode
        if (known) begin
            if (mod == cu_pkg::MOD_INDIRECT) begin
                addr_route = rm[0] ? cu_pkg::st_addr_sum0 : cu_pkg::st_addr_reg;
            end else begin
                addr_route = src_route;
            end
        end
    end

endmodule

// File: hdl/cu_pkg.sv
package cu_pkg;

    typedef logic [0:15] word_t;      // Bit 0 is the most significant
    typedef logic [2:0]  reg_addr_t;

    // Instruction fields, numbered like the instruction word
    typedef logic [0:3] cls_t;
    typedef logic [0:2] subop_t;
    typedef logic [0:1] mod_t;
    typedef logic [0:2] rfield_t;

    localparam reg_addr_t REG_RA = 3'd0;
    localparam reg_addr_t REG_RB = 3'd1;
    localparam reg_addr_t REG_RC = 3'd2;
    localparam reg_addr_t REG_IS = 3'd3;
    localparam reg_addr_t REG_XA = 3'd4;
    localparam reg_addr_t REG_XB = 3'd5;
    localparam reg_addr_t REG_BA = 3'd6;
    localparam reg_addr_t REG_BB = 3'd7;

    typedef enum logic [3:0] {
        ALU_ADC  = 4'd0,
        ALU_SBB1 = 4'd1,    // a - b - carry
        ALU_SBB2 = 4'd2,    // b - a - carry
        ALU_NOT  = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SHL  = 4'd7,
        ALU_SHR  = 4'd8,
        ALU_SAR  = 4'd9
    } alu_op_e;

    typedef enum logic [4:0] {
        st_reset,
        st_fetch0, st_fetch1, st_fetch2,
        st_decode,
        st_addr_sum0, st_addr_sum1, st_addr_sum2,
        st_addr_reg,
        st_src_reg,
        st_src_mem0, st_src_mem1, st_src_mem2,
        st_dst_reg,
        st_dst_mem0, st_dst_mem1, st_dst_mem2,
        st_exec_1op, st_exec_2op,
        st_store_reg,
        st_store_mem0, st_store_mem1,
        st_inc_cp0, st_inc_cp1,
        st_jmp
    } state_t;

    localparam cls_t CLS_XFER        = 4'b0000;    // JMP is sub-op 101
    localparam cls_t CLS_1OP         = 4'b0001;
    localparam cls_t CLS_2OP_NOSTORE = 4'b0100;
    localparam cls_t CLS_2OP_STORE   = 4'b0101;

    localparam subop_t SUBOP_JMP = 3'b101;

    localparam mod_t MOD_INDIRECT = 2'b00;
    localparam mod_t MOD_REG      = 2'b11;

    localparam int FLAG_CARRY = 0;

endpackage
